// File: board_top.f
+incdir+hw
hw/panel_pkg.sv
hw/serial_pkg.sv
hw/key_sampler.sv
hw/key_debounce.sv
hw/key_feedback.sv
hw/uart_rx.sv
hw/byte_display.sv
hw/board_top.sv
tb/tb_board_top.sv

// File: tb/tb_board_top.sv
/* front-panel controller testbench
   clock and reset, key and serial stimulus, assertion checks */
`timescale 1ns/1ps
`include "board_config.svh"

module tb_board_top;

	localparam int BIT_CLKS  = 217;
	localparam int TICK      = `TICK_DIV;
	localparam int BEEP_HALF = `BEEP_HALF;

	logic                  sys_clk = 1'b0;
	logic                  sys_rst_n;
	logic [`KEY_COUNT-1:0] key_in;
	logic                  uart_rx_port;
	logic [7:0]            led;
	logic                  beeper;
	logic [7:0]            seg_number;
	logic [7:0]            seg_choice;

	int                    mismatches  = 0;
	int                    failures    = 0;
	int                    cycle       = 0;
	int                    last_fall   = 0;
	logic                  beeper_prev = 1'b0;
	logic [31:0]           rng_state   = 32'd60606;
	logic                  disp_check  = 1'b0;
	logic [7:0]            digits_seen = '0;
	logic [7:0]            exp_latest  = '0;
	logic [7:0]            exp_older   = '0;
	logic [`KEY_COUNT-1:0] exp_toggle  = '0;

	board_top dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.led          (led),
		.beeper       (beeper),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	// 40 ns period
	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// lit segments g..a per hex digit then inverted for active low
	function automatic logic [7:0] hex_pattern(input logic [3:0] value);
		logic [6:0] lit;
		case (value)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~{1'b0, lit};
	endfunction

	function automatic int count_low(input logic [7:0] lines);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			if (!lines[i])
				n++;
		return n;
	endfunction

	function automatic int low_index(input logic [7:0] lines);
		int idx;
		idx = 0;
		for (int i = 7; i >= 0; i--)
			if (!lines[i])
				idx = i;
		return idx;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			mismatches++;
			$display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic print_summary();
		$display("summary: %0d mismatches, %0d other failures", mismatches, failures);
	endtask

	task automatic timeout_abort(input string what);
		failures++;
		$display("timeout while waiting for %s", what);
		print_summary();
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// record cycle of each beeper falling edge
	always @(negedge sys_clk) begin
		if (beeper_prev && !beeper)
			last_fall = cycle;
		beeper_prev = beeper;
	end

	// at most one select line low and segments match the selected digit
	always @(negedge sys_clk) begin
		int         lows;
		int         d;
		logic [7:0] exp_seg;
		lows = count_low(seg_choice);
		if (sys_rst_n) begin
			assert (lows <= 1) else begin
				mismatches++;
				$display("Mismatch select_one_low: expected at most 1, actual %0d", lows);
			end
			if (disp_check && lows == 1) begin
				d = low_index(seg_choice);
				case (d)
					0: exp_seg = hex_pattern(exp_latest[3:0]);
					1: exp_seg = hex_pattern(exp_latest[7:4]);
					3: exp_seg = hex_pattern(exp_older[3:0]);
					4: exp_seg = hex_pattern(exp_older[7:4]);
					default: exp_seg = 8'hff;
				endcase
				check_eq($sformatf("display_digit%0d", d), exp_seg, seg_number);
				digits_seen[d] = 1'b1;
			end
		end
	end

	task automatic wait_led(input int idx, input logic val, input int limit, input string what);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (led[idx] !== val) begin
			if (n >= limit)
				timeout_abort(what);
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic wait_beeper_high(input int limit, output int n);
		n = 0;
		@(negedge sys_clk);
		while (beeper !== 1'b1) begin
			if (n >= limit)
				timeout_abort("beeper to start");
			@(negedge sys_clk);
			n++;
		end
	endtask

	// beep over once the line stays low longer than a tone period
	task automatic wait_beeper_quiet(input int limit);
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < 2 * BEEP_HALF + 4) begin
			if (n >= limit)
				timeout_abort("beeper to go quiet");
			@(negedge sys_clk);
			n++;
			quiet = beeper ? 0 : quiet + 1;
		end
	endtask

	task automatic wait_all_digits();
		int n;
		n = 0;
		digits_seen = '0;
		disp_check = 1'b1;
		while (digits_seen !== 8'hff) begin
			if (n >= 10 * `SCAN_DIV)
				timeout_abort("display scan over all digits");
			@(negedge sys_clk);
			n++;
		end
		disp_check = 1'b0;
	endtask

	task automatic clean_press(input int k, input string name);
		logic exp_led;
		int   t0;
		int   rise;
		int   dur;
		exp_led = !exp_toggle[k];
		exp_toggle[k] = exp_led;
		@(posedge sys_clk);
		key_in[k] <= 1'b0;
		wait_led(k, exp_led, 20 * TICK, "press to toggle led");
		t0 = cycle;
		check_eq($sformatf("%s_level_led", name), 1, led[k + 4]);
		wait_beeper_high(4 * BEEP_HALF, rise);
		assert (rise <= BEEP_HALF + 2) else begin
			mismatches++;
			$display("Mismatch %s_beep_start: expected %0d, actual %0d", name, BEEP_HALF + 2, rise);
		end
		@(posedge sys_clk);
		key_in[k] <= 1'b1;
		wait_led(k + 4, 1'b0, 20 * TICK, "release to clear level led");
		check_eq($sformatf("%s_toggle_led", name), exp_led, led[k]);
		wait_beeper_quiet(60 * TICK);
		dur = last_fall - t0;
		assert (dur >= 49 * TICK && dur <= 51 * TICK) else begin
			mismatches++;
			$display("Mismatch %s_beep_length: expected %0d, actual %0d", name, 50 * TICK, dur);
		end
	endtask

	// every stretch holds at least one tick sample and stays well under the debounce length
	task automatic bouncy_press(input int k);
		logic beep_seen;
		int   hold;
		beep_seen = 1'b0;
		for (int i = 0; i < 8; i++) begin
			hold = TICK + 2 + int'(next_random() % (3 * TICK));
			@(posedge sys_clk);
			key_in[k] <= i[0];
			repeat (hold) @(posedge sys_clk);
		end
		repeat (20 * TICK) begin
			@(negedge sys_clk);
			if (beeper)
				beep_seen = 1'b1;
		end
		check_eq("bounce_led", exp_toggle, led);
		check_eq("bounce_beeper", 0, beep_seen);
	endtask

	// 8N1 frame sent LSB first
	task automatic send_frame(input logic [7:0] data, input logic stop_bit, input int stop_clks);
		@(posedge sys_clk);
		uart_rx_port <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(posedge sys_clk);
			uart_rx_port <= data[i];
		end
		repeat (BIT_CLKS) @(posedge sys_clk);
		uart_rx_port <= stop_bit;
		repeat (stop_clks) @(posedge sys_clk);
		uart_rx_port <= 1'b1;
		repeat (2 * BIT_CLKS) @(posedge sys_clk);
	endtask

	initial begin
		int          k;
		logic [31:0] r;
		logic [7:0]  byte_a;
		logic [7:0]  byte_b;
		sys_rst_n = 1'b0;
		key_in = '1;
		uart_rx_port = 1'b1;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		@(negedge sys_clk);
		check_eq("reset_led", 0, led);
		check_eq("reset_beeper", 0, beeper);
		// both stored bytes start at zero
		wait_all_digits();

		r = next_random();
		k = int'(r % `KEY_COUNT);
		clean_press(k, "first_press");
		clean_press(k, "second_press");
		bouncy_press(k);

		r = next_random();
		byte_a = r[7:0];
		r = next_random();
		byte_b = r[7:0];
		send_frame(byte_a, 1'b1, BIT_CLKS);
		send_frame(byte_b, 1'b1, BIT_CLKS);
		exp_older = byte_a;
		exp_latest = byte_b;
		wait_all_digits();

		// low stop bit released early so no false start follows
		send_frame(byte_a ^ byte_b ^ 8'h5a, 1'b0, 3 * BIT_CLKS / 4);
		wait_all_digits();

		print_summary();
		if (mismatches == 0 && failures == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: hw/board_top.sv
/* board top level
   key sampler, debouncer array, key feedback, serial receiver, display */
`timescale 1ns/1ps
`include "board_config.svh"

module board_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [`KEY_COUNT-1:0] key_in,
	input  logic                  uart_rx_port,
	output logic [7:0]            led,
	output logic                  beeper,
	output logic [7:0]            seg_number,
	output logic [7:0]            seg_choice
);
	import panel_pkg::*;
	import serial_pkg::*;

	key_vec_t   keys;
	key_vec_t   key_level;
	key_vec_t   key_press;
	key_event_t events;
	logic       tick;
	rx_byte_t   rx_byte;
	seg_drive_t seg;

	key_sampler u_sampler (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.keys      (keys),
		.tick      (tick)
	);

	// one debouncer per key, all on the shared tick
	for (genvar i = 0; i < `KEY_COUNT; i++) begin : g_debounce
		key_debounce u_debounce (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.key       (keys[i]),
			.tick      (tick),
			.level     (key_level[i]),
			.press     (key_press[i])
		);
	end

	assign events.level = key_level;
	assign events.press = key_press;

	key_feedback u_feedback (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.events    (events),
		.tick      (tick),
		.led       (led),
		.beeper    (beeper)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte)
	);

	byte_display u_display (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.seg       (seg)
	);

	assign seg_number = seg.segments;
	assign seg_choice = seg.select;

endmodule

// File: hw/byte_display.sv
/* two-byte history shown as hex on the eight-digit display
   byte latch, digit scan and active-low segment decode */
`timescale 1ns/1ps
`include "board_config.svh"

module byte_display (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  serial_pkg::rx_byte_t  rx_byte,
	output panel_pkg::seg_drive_t seg
);
	import panel_pkg::*;

	localparam int SCAN_W = $clog2(`SCAN_DIV);

	logic [7:0]        latest;
	logic [7:0]        older;
	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        digit;
	logic [3:0]        nibble;
	logic              blank;
	seg_drive_t        seg_next;

	// hex digit to dp g f e d c b a, active low
	function automatic logic [7:0] hex_seg(input logic [3:0] value);
		case (value)
			4'h0: hex_seg = 8'hc0;
			4'h1: hex_seg = 8'hf9;
			4'h2: hex_seg = 8'ha4;
			4'h3: hex_seg = 8'hb0;
			4'h4: hex_seg = 8'h99;
			4'h5: hex_seg = 8'h92;
			4'h6: hex_seg = 8'h82;
			4'h7: hex_seg = 8'hf8;
			4'h8: hex_seg = 8'h80;
			4'h9: hex_seg = 8'h90;
			4'ha: hex_seg = 8'h88;
			4'hb: hex_seg = 8'h83;
			4'hc: hex_seg = 8'hc6;
			4'hd: hex_seg = 8'ha1;
			4'he: hex_seg = 8'h86;
			default: hex_seg = 8'h8e;
		endcase
	endfunction

	// good frames only, previous byte shifts to older
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			latest <= '0;
			older  <= '0;
		end else if (rx_byte.valid && !rx_byte.frame_err) begin
			latest <= rx_byte.data;
			older  <= latest;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt <= '0;
			digit    <= '0;
		end else if (scan_cnt == SCAN_W'(`SCAN_DIV - 1)) begin
			scan_cnt <= '0;
			digit    <= digit + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_comb begin
		blank  = 1'b0;
		nibble = 4'h0;
		case (digit)
			3'd0: nibble = latest[3:0];
			3'd1: nibble = latest[7:4];
			3'd3: nibble = older[3:0];
			3'd4: nibble = older[7:4];
			default: blank = 1'b1;
		endcase
		seg_next.segments = blank ? 8'hff : hex_seg(nibble);
		seg_next.select   = ~(8'b1 << digit);
	end

	// all digits dark during reset
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			seg <= '1;
		else
			seg <= seg_next;
	end

endmodule

// File: hw/uart_rx.sv
/* 8N1 serial receiver
   mid-bit sampling, LSB first, stop-bit framing check */
`timescale 1ns/1ps
`include "board_config.svh"

module uart_rx (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 rx,
	output serial_pkg::rx_byte_t rx_byte
);

	localparam int BIT_CLKS = `CLK_HZ / `BAUD_RATE;
	localparam int HALF_CLKS = BIT_CLKS / 2;
	localparam int CLK_W = $clog2(BIT_CLKS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CLK_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= ST_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			shift   <= '0;
			rx_byte <= '0;
		end else begin
			rx_byte.valid <= 1'b0;
			clk_cnt       <= clk_cnt + 1'b1;
			case (state)
				ST_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= ST_START;
				end
				ST_START: begin
					// recheck at mid-bit, glitches go back to idle
					if (clk_cnt == CLK_W'(HALF_CLKS - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? ST_IDLE : ST_DATA;
					end
				end
				ST_DATA: begin
					if (clk_cnt == CLK_W'(BIT_CLKS - 1)) begin
						clk_cnt <= '0;
						shift   <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= ST_STOP;
					end
				end
				default: begin
					// middle of stop bit
					if (clk_cnt == CLK_W'(BIT_CLKS - 1)) begin
						rx_byte.data      <= shift;
						rx_byte.valid     <= 1'b1;
						rx_byte.frame_err <= ~rx_sync;
						state             <= ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/key_feedback.sv
/* key feedback on LEDs and beeper
   toggle LEDs on press, level LEDs while held, timed 1 kHz beep */
`timescale 1ns/1ps
`include "board_config.svh"

module key_feedback (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  panel_pkg::key_event_t events,
	input  logic                  tick,
	output logic [7:0]            led,
	output logic                  beeper
);
	import panel_pkg::*;

	localparam int BEEP_W = $clog2(`BEEP_TICKS + 1);
	localparam int TONE_W = $clog2(`BEEP_HALF);

	key_vec_t          led_toggle;
	key_vec_t          led_level;
	logic [BEEP_W-1:0] beep_cnt;
	logic [TONE_W-1:0] tone_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			led_toggle <= '0;
			led_level  <= '0;
		end else begin
			led_toggle <= led_toggle ^ events.press;
			led_level  <= events.level;
		end
	end

	// upper half mirrors held keys
	assign led = {led_level, led_toggle};

	// beep length in ticks, any press restarts it
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			beep_cnt <= '0;
		else if (|events.press)
			beep_cnt <= BEEP_W'(`BEEP_TICKS);
		else if (tick && beep_cnt != '0)
			beep_cnt <= beep_cnt - 1'b1;
	end

	// tone divider, silent outside a beep
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tone_cnt <= '0;
			beeper   <= 1'b0;
		end else if (beep_cnt == '0) begin
			tone_cnt <= '0;
			beeper   <= 1'b0;
		end else if (tone_cnt == TONE_W'(`BEEP_HALF - 1)) begin
			tone_cnt <= '0;
			beeper   <= ~beeper;
		end else begin
			tone_cnt <= tone_cnt + 1'b1;
		end
	end

endmodule

// File: hw/key_debounce.sv
/* single-key debouncer
   accepts a new level after DEBOUNCE_TICKS equal samples, pulses on press */
`timescale 1ns/1ps
`include "board_config.svh"

module key_debounce (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic key,
	input  logic tick,
	output logic level,
	output logic press
);

	localparam int CNT_W = $clog2(`DEBOUNCE_TICKS);

	// consecutive samples that disagree with level
	logic [CNT_W-1:0] diff_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level    <= 1'b0;
			press    <= 1'b0;
			diff_cnt <= '0;
		end else begin
			press <= 1'b0;
			if (tick) begin
				if (key == level) begin
					// bounce back, start over
					diff_cnt <= '0;
				end else if (diff_cnt == CNT_W'(`DEBOUNCE_TICKS - 1)) begin
					// stable long enough, flip
					level    <= key;
					press    <= key;
					diff_cnt <= '0;
				end else begin
					diff_cnt <= diff_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: hw/key_sampler.sv
/* key input synchronizer and shared 1 ms sample tick */
`timescale 1ns/1ps
`include "board_config.svh"

module key_sampler (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  panel_pkg::key_vec_t key_in,
	output panel_pkg::key_vec_t keys,
	output logic                tick
);
	import panel_pkg::*;

	localparam int TICK_W = $clog2(`TICK_DIV);

	key_vec_t          key_meta;
	key_vec_t          key_sync;
	logic [TICK_W-1:0] tick_cnt;

	// two-flop sync, raw keys idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
		end
	end

	// pressed reads as 1 from here on
	assign keys = ~key_sync;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else if (tick_cnt == TICK_W'(`TICK_DIV - 1)) begin
			tick_cnt <= '0;
			tick     <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick     <= 1'b0;
		end
	end

endmodule

// File: hw/serial_pkg.sv
/* serial receive types
   one received byte with strobe and framing status */

package serial_pkg;

	// byte from the microcontroller link
	typedef struct packed {
		logic [7:0] data;
		// one-cycle strobe
		logic       valid;
		// stop bit read low
		logic       frame_err;
	} rx_byte_t;

endpackage

// File: hw/panel_pkg.sv
/* front-panel types
   key vectors, debounced key events and seven-segment drive */
`include "board_config.svh"

package panel_pkg;

	// one bit per push-button
	typedef logic [`KEY_COUNT-1:0] key_vec_t;

	// debounced key state
	typedef struct packed {
		// high while key held
		key_vec_t level;
		// one-cycle pulse per accepted press
		key_vec_t press;
	} key_event_t;

	// display lines, both active low
	typedef struct packed {
		// dp g f e d c b a
		logic [7:0] segments;
		// one digit low at a time
		logic [7:0] select;
	} seg_drive_t;

endpackage

// File: hw/board_config.svh
/* board-level constants for the front-panel controller
   clock and baud rate, key count, tick, debounce, beep and scan timing */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// system clock and serial line
`define CLK_HZ          25_000_000
`define BAUD_RATE       115_200

// push-buttons
`define KEY_COUNT       4
// clocks per 1 ms sample tick
`define TICK_DIV        25_000
`define DEBOUNCE_TICKS  16

// beeper, length in ticks and half period in clocks (1 kHz)
`define BEEP_TICKS      50
`define BEEP_HALF       12_500

// clocks each display digit stays lit
`define SCAN_DIV        2_500

`endif
